//--- Makefile
# Verilator build and run of the dual-issue slice testbench.

TOOL      = verilator
FLAGS     = --binary --timing
TOP       = tb_dual_issue
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F -- '** PASS **' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb.f
verilog/dual_issue_pkg.sv
verilog/issue_if.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/dual_issue_core.sv
testbench/tb_dual_issue.sv

//--- testbench/tb_dual_issue.sv
/*
 Testbench for the dual-issue register read and execute slice.
 Drives random instruction pairs, keeps a register model and checks
 every retired pair and the one-cycle retire latency.
*/

`timescale 1ns/100ps

module tb_dual_issue;

   typedef struct packed {
      dual_issue_pkg::reg_addr_t rd0;
      dual_issue_pkg::reg_addr_t rd1;
      dual_issue_pkg::data_t     d0;
      dual_issue_pkg::data_t     d1;
   } retire_t;

   localparam int DRAIN_LIMIT = 20;                // Cycles allowed for the last retires.

   logic                      CLK = 1'b0;
   logic                      RST;
   logic                      issue_valid;
   dual_issue_pkg::insn_t     insn0;
   dual_issue_pkg::insn_t     insn1;
   logic                      retire_valid;
   dual_issue_pkg::reg_addr_t retire_rd0;
   dual_issue_pkg::reg_addr_t retire_rd1;
   dual_issue_pkg::data_t     retire_data0;
   dual_issue_pkg::data_t     retire_data1;

   dual_issue_pkg::data_t model_regs [16];         // Architectural state as the model sees it.
   retire_t     expect_q [$];                      // Expected retires, oldest first.
   string       name_q [$];                        // Test name of each queued pair.
   retire_t     head;
   string       head_name;
   logic [1:0]  issue_pipe;                        // Issue strobes seen at the last two negedges.
   logic [31:0] lcg_state = 32'd8415;
   int data_errors  = 0;
   int rd_errors    = 0;
   int proto_errors = 0;
   int issue_count  = 0;
   int retire_count = 0;

   always #20 CLK = ~CLK;                          // 40 ns period.

   dual_issue_core dut0 (
      .CLK          (CLK),
      .RST          (RST),
      .issue_valid  (issue_valid),
      .insn0        (insn0),
      .insn1        (insn1),
      .retire_valid (retire_valid),
      .retire_rd0   (retire_rd0),
      .retire_rd1   (retire_rd1),
      .retire_data0 (retire_data0),
      .retire_data1 (retire_data1)
   );

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345; // Fixed-seed LCG.
      return lcg_state;
   endfunction

   // Layout from the top bit down is opcode, rd, rs1, rs2 and two spare bits.
   function automatic dual_issue_pkg::insn_t make_insn(input dual_issue_pkg::alu_op_e op,
      input dual_issue_pkg::reg_addr_t rd, input dual_issue_pkg::reg_addr_t rs1,
      input dual_issue_pkg::reg_addr_t rs2);
      return {op, rd, rs1, rs2, 2'b00};
   endfunction

   function automatic dual_issue_pkg::data_t model_alu(input logic [1:0] code,
      input dual_issue_pkg::data_t a, input dual_issue_pkg::data_t b);
      case (code)
         2'd0:    return a + b;
         2'd1:    return a - b;                    // rs1 minus rs2.
         2'd2:    return a ^ b;
         default: return a & b;
      endcase
   endfunction

   task automatic check_data(input string name, input dual_issue_pkg::data_t exp,
      input dual_issue_pkg::data_t act);
      if (act !== exp) begin
         $display("FAILED %s data: expected %h, actual %h", name, exp, act);
         data_errors++;
      end
   endtask

   task automatic check_rd(input string name, input dual_issue_pkg::reg_addr_t exp,
      input dual_issue_pkg::reg_addr_t act);
      if (act !== exp) begin
         $display("FAILED %s rd: expected %h, actual %h", name, exp, act);
         rd_errors++;
      end
   endtask

   // Both slots see the state before the pair, then slot 0 and slot 1 write in order.
   task automatic issue_pair(input string name, input dual_issue_pkg::insn_t i0,
      input dual_issue_pkg::insn_t i1);
      retire_t entry;
      entry.rd0 = i0[13:10];
      entry.rd1 = i1[13:10];
      entry.d0  = model_alu(i0[15:14], model_regs[i0[9:6]], model_regs[i0[5:2]]);
      entry.d1  = model_alu(i1[15:14], model_regs[i1[9:6]], model_regs[i1[5:2]]);
      model_regs[entry.rd0] = entry.d0;
      model_regs[entry.rd1] = entry.d1;           // Slot 1 lands last and wins.
      expect_q.push_back(entry);
      name_q.push_back(name);
      @(posedge CLK);
      issue_valid <= 1'b1;
      insn0       <= i0;
      insn1       <= i1;
      issue_count++;
   endtask

   // Junk on the instruction inputs must be ignored while the strobe is low.
   task automatic idle_cycles(input int n);
      logic [31:0] r;
      repeat (n) begin
         r = next_rand();
         @(posedge CLK);
         issue_valid <= 1'b0;
         insn0       <= r[31:16];
         insn1       <= r[15:0];
      end
   endtask

   // A pair sampled at one edge must retire at the next and at no other time.
   always @(negedge CLK) begin
      if (!RST) begin
         issue_pipe = 2'b00;
      end else begin
         if (retire_valid !== issue_pipe[1]) begin
            if (retire_valid === 1'b1) $display("ERROR: retire_valid high without an issue");
            else $display("ERROR: retire_valid missing one cycle after an issue");
            proto_errors++;
         end
         if (retire_valid === 1'b1) begin
            retire_count++;
            if (expect_q.size() == 0) begin
               $display("ERROR: a pair retired while none was in flight");
               proto_errors++;
            end else begin
               head      = expect_q.pop_front();
               head_name = name_q.pop_front();
               check_rd(head_name, head.rd0, retire_rd0);
               check_rd(head_name, head.rd1, retire_rd1);
               check_data(head_name, head.d0, retire_data0);
               check_data(head_name, head.d1, retire_data1);
            end
         end
         issue_pipe = {issue_pipe[0], issue_valid};
      end
   end

   initial begin
      logic [31:0] r;
      dual_issue_pkg::reg_addr_t prev_rd0;
      dual_issue_pkg::reg_addr_t prev_rd1;
      dual_issue_pkg::reg_addr_t w;
      int waited;
      RST         = 1'b0;
      issue_valid = 1'b0;
      insn0       = '0;
      insn1       = '0;
      for (int i = 0; i < 16; i++) begin
         model_regs[i] = {4{8'(i)}};              // Index repeated in every byte.
      end
      repeat (4) @(posedge CLK);
      RST <= 1'b1;

      // XOR then AND of each register with itself. Slot 1 restores the value.
      for (int i = 0; i < 16; i++) begin
         w = 4'(i);
         issue_pair("reset_image", make_insn(dual_issue_pkg::OP_XOR, w, w, w),
                    make_insn(dual_issue_pkg::OP_AND, w, w, w));
      end

      for (int k = 0; k < 200; k++) begin
         r = next_rand();
         issue_pair("random_ops", r[31:16], r[15:0]); // Spare bits stay random.
         r = next_rand();
         idle_cycles(int'(r[29:28]) % 3);
      end

      r        = next_rand();
      prev_rd0 = r[31:28];
      prev_rd1 = r[27:24];
      issue_pair("forwarding", make_insn(dual_issue_pkg::OP_ADD, prev_rd0, r[23:20], r[19:16]),
                 make_insn(dual_issue_pkg::OP_SUB, prev_rd1, r[15:12], r[11:8]));
      for (int k = 0; k < 40; k++) begin
         r = next_rand();
         issue_pair("forwarding",
            make_insn(dual_issue_pkg::alu_op_e'(r[31:30]), r[27:24],
                      r[23] ? prev_rd1 : prev_rd0, r[22] ? prev_rd1 : prev_rd0),
            make_insn(dual_issue_pkg::alu_op_e'(r[29:28]), r[19:16],
                      r[21] ? prev_rd1 : prev_rd0, r[20] ? prev_rd1 : prev_rd0));
         prev_rd0 = r[27:24];
         prev_rd1 = r[19:16];
      end

      // Odd rounds leave a gap so the read comes from the array, not the bypass.
      for (int k = 0; k < 20; k++) begin
         r = next_rand();
         w = r[3:0];
         issue_pair("waw_priority", make_insn(dual_issue_pkg::OP_ADD, w, r[31:28], r[27:24]),
                    make_insn(dual_issue_pkg::OP_XOR, w, r[23:20], r[19:16]));
         if (k % 2 == 1) idle_cycles(1);
         issue_pair("waw_read", make_insn(dual_issue_pkg::OP_ADD, r[15:12], w, w),
                    make_insn(dual_issue_pkg::OP_AND, r[11:8], w, r[7:4]));
      end

      idle_cycles(1);
      waited = 0;
      while (expect_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(posedge CLK);
         waited++;
      end
      if (expect_q.size() != 0) begin
         $display("ERROR: timed out with %0d pairs still waiting to retire", expect_q.size());
         proto_errors++;
      end
      idle_cycles(3);
      if (retire_count != issue_count) begin
         $display("ERROR: %0d pairs issued but %0d retired", issue_count, retire_count);
         proto_errors++;
      end

      $display("Errors: data %0d, rd %0d, protocol %0d", data_errors, rd_errors, proto_errors);
      if (data_errors == 0 && rd_errors == 0 && proto_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- verilog/decode_stage.sv
/*
 Decode stage.
 Splits an instruction pair into fields, drives the four register read
 ports and registers the decoded pair onto the issue bus.
*/

`timescale 1ns/100ps

module decode_stage (
   input  logic                  CLK,
   input  logic                  RST,
   input  logic                  issue_valid,
   input  dual_issue_pkg::insn_t insn0,
   input  dual_issue_pkg::insn_t insn1,
   output logic [dual_issue_pkg::NUM_RD_PORTS-1:0]                        re,
   output logic [dual_issue_pkg::NUM_RD_PORTS*dual_issue_pkg::REG_AW-1:0] raddr,
   issue_if.producer             iss
);

   localparam int AW = dual_issue_pkg::REG_AW;     // Short name for slicing.

   dual_issue_pkg::insn_t insn [dual_issue_pkg::ISSUE_W]; // Pair indexed by slot.

   assign insn[0] = insn0;
   assign insn[1] = insn1;

   // All four ports read whenever a pair arrives.
   assign re = {dual_issue_pkg::NUM_RD_PORTS{issue_valid}};

   // Port 2s reads rs1 and port 2s+1 reads rs2 of slot s.
   always_comb begin
      for (int s = 0; s < dual_issue_pkg::ISSUE_W; s++) begin
         raddr[(2*s)*AW +: AW]   = insn[s][dual_issue_pkg::RS1_LSB +: AW];
         raddr[(2*s+1)*AW +: AW] = insn[s][dual_issue_pkg::RS2_LSB +: AW];
      end
   end

   // High in the cycle after each issue strobe.
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         iss.valid <= 1'b0;
      end else begin
         iss.valid <= issue_valid;                 // Lines up with the registered rdata.
      end
   end

   // Field registers only load with a new pair.
   always_ff @(posedge CLK) begin
      if (issue_valid) begin
         for (int s = 0; s < dual_issue_pkg::ISSUE_W; s++) begin
            iss.op[s]  <= dual_issue_pkg::alu_op_e'(
                             insn[s][dual_issue_pkg::OP_LSB +: dual_issue_pkg::OP_W]);
            iss.rd[s]  <= insn[s][dual_issue_pkg::RD_LSB +: AW];
            iss.rs1[s] <= insn[s][dual_issue_pkg::RS1_LSB +: AW]; // Kept for forwarding.
            iss.rs2[s] <= insn[s][dual_issue_pkg::RS2_LSB +: AW];
         end
      end
   end

endmodule

//--- verilog/dual_issue_core.sv
/*
 Dual-issue register read and execute slice.
 Joins decode, the register file and execute. A pair issued at one
 edge retires at the next.
*/

`timescale 1ns/100ps

module dual_issue_core (
   input  logic                      CLK,
   input  logic                      RST,
   input  logic                      issue_valid,
   input  dual_issue_pkg::insn_t     insn0,
   input  dual_issue_pkg::insn_t     insn1,
   output logic                      retire_valid,
   output dual_issue_pkg::reg_addr_t retire_rd0,
   output dual_issue_pkg::reg_addr_t retire_rd1,
   output dual_issue_pkg::data_t     retire_data0,
   output dual_issue_pkg::data_t     retire_data1
);

   localparam int NRD = dual_issue_pkg::NUM_RD_PORTS; // Read port count.
   localparam int NWR = dual_issue_pkg::ISSUE_W;      // One write port per slot.
   localparam int DW  = dual_issue_pkg::DATA_W;
   localparam int AW  = dual_issue_pkg::REG_AW;

   logic [NRD-1:0]    re;                          // Read enables from decode.
   logic [NRD*AW-1:0] raddr;                       // Read addresses from decode.
   logic [NRD*DW-1:0] rdata;                       // Registered read data to execute.
   logic [NWR-1:0]    we;                          // Write enables from execute.
   logic [NWR*AW-1:0] waddr;
   logic [NWR*DW-1:0] wdata;

   issue_if iss_bus ();                            // Decoded pair, decode to execute.

   decode_stage u_decode (
      .CLK         (CLK),
      .RST         (RST),
      .issue_valid (issue_valid),
      .insn0       (insn0),
      .insn1       (insn1),
      .re          (re),
      .raddr       (raddr),
      .iss         (iss_bus)
   );

   register_file #(
      .DW         (DW),
      .AW         (AW),
      .NUM_READ   (NRD),
      .NUM_WRITE  (NWR),
      .RST_VECTOR (dual_issue_pkg::REG_RESET_VECTOR)
   ) u_regfile (
      .CLK   (CLK),
      .RST   (RST),
      .re    (re),
      .raddr (raddr),
      .rdata (rdata),
      .we    (we),
      .waddr (waddr),
      .wdata (wdata)
   );

   execute_stage u_execute (
      .CLK          (CLK),
      .RST          (RST),
      .iss          (iss_bus),
      .rdata        (rdata),
      .we           (we),
      .waddr        (waddr),
      .wdata        (wdata),
      .retire_valid (retire_valid),
      .retire_rd0   (retire_rd0),
      .retire_rd1   (retire_rd1),
      .retire_data0 (retire_data0),
      .retire_data1 (retire_data1)
   );

endmodule

//--- verilog/dual_issue_pkg.sv
/*
 Dual-issue slice shared definitions.
 Widths, register and instruction typedefs, the ALU opcode encoding
 and the reset image of the register file.
*/

package dual_issue_pkg;

   localparam int DATA_W       = 32;                // Width of one register.
   localparam int REG_AW       = 4;                 // Register number width.
   localparam int NUM_REGS     = 1 << REG_AW;       // Sixteen architectural registers.
   localparam int ISSUE_W      = 2;                 // Slots in one instruction pair.
   localparam int NUM_RD_PORTS = 2 * ISSUE_W;       // Two source operands per slot.
   localparam int INSN_W       = 16;                // Width of one instruction word.
   localparam int OP_W         = 2;                 // Opcode field width.

   // Field positions inside an instruction word, counted from bit 0.
   localparam int OP_LSB  = 14;                     // Opcode sits in the top two bits.
   localparam int RD_LSB  = 10;                     // Destination register.
   localparam int RS1_LSB = 6;                      // First source register.
   localparam int RS2_LSB = 2;                      // Second source. Bits 1:0 are spare.

   typedef logic [DATA_W-1:0] data_t;               // Register value.
   typedef logic [REG_AW-1:0] reg_addr_t;           // Register number.
   typedef logic [INSN_W-1:0] insn_t;               // Raw instruction word.

   typedef enum logic [OP_W-1:0] {
      OP_ADD = 2'd0,                                // rs1 plus rs2.
      OP_SUB = 2'd1,                                // rs1 minus rs2.
      OP_XOR = 2'd2,
      OP_AND = 2'd3
   } alu_op_e;

   // Builds the reset image. Each byte of register i holds the value i.
   function automatic logic [DATA_W*NUM_REGS-1:0] reset_image();
      logic [DATA_W*NUM_REGS-1:0] img;
      img = '0;
      for (int i = 0; i < NUM_REGS; i++) begin
         img[i*DATA_W +: DATA_W] = {(DATA_W/8){8'(i)}}; // Index copied into every byte.
      end
      return img;
   endfunction

   localparam logic [DATA_W*NUM_REGS-1:0] REG_RESET_VECTOR = reset_image();

endpackage

//--- verilog/execute_stage.sv
/*
 Execute stage.
 Forwards the previous pair's results over stale register data, runs
 one ALU operation per slot, writes both results back and registers
 the retire outputs.
*/

`timescale 1ns/100ps

module execute_stage (
   input  logic                       CLK,
   input  logic                       RST,
   issue_if.consumer                  iss,
   input  logic [dual_issue_pkg::NUM_RD_PORTS*dual_issue_pkg::DATA_W-1:0] rdata,
   output logic [dual_issue_pkg::ISSUE_W-1:0]                        we,
   output logic [dual_issue_pkg::ISSUE_W*dual_issue_pkg::REG_AW-1:0] waddr,
   output logic [dual_issue_pkg::ISSUE_W*dual_issue_pkg::DATA_W-1:0] wdata,
   output logic                       retire_valid,
   output dual_issue_pkg::reg_addr_t  retire_rd0,
   output dual_issue_pkg::reg_addr_t  retire_rd1,
   output dual_issue_pkg::data_t      retire_data0,
   output dual_issue_pkg::data_t      retire_data1
);

   localparam int DW = dual_issue_pkg::DATA_W;     // Short names for slicing.
   localparam int AW = dual_issue_pkg::REG_AW;

   dual_issue_pkg::data_t opa    [dual_issue_pkg::ISSUE_W]; // First operand per slot.
   dual_issue_pkg::data_t opb    [dual_issue_pkg::ISSUE_W]; // Second operand per slot.
   dual_issue_pkg::data_t result [dual_issue_pkg::ISSUE_W]; // ALU output per slot.

   // The last pair's writes land at the same edge this pair read, so its results bypass rdata.
   // Slot 1 is checked first to match the write priority of the register file.
   function automatic dual_issue_pkg::data_t forward(
      input dual_issue_pkg::reg_addr_t addr,
      input dual_issue_pkg::data_t     rf_val
   );
      dual_issue_pkg::data_t val;
      val = rf_val;
      if (retire_valid && (retire_rd1 == addr)) begin
         val = retire_data1;
      end else if (retire_valid && (retire_rd0 == addr)) begin
         val = retire_data0;
      end
      return val;
   endfunction

   function automatic dual_issue_pkg::data_t alu(
      input dual_issue_pkg::alu_op_e op,
      input dual_issue_pkg::data_t   a,
      input dual_issue_pkg::data_t   b
   );
      case (op)
         dual_issue_pkg::OP_ADD: return a + b;
         dual_issue_pkg::OP_SUB: return a - b;    // rs1 minus rs2.
         dual_issue_pkg::OP_XOR: return a ^ b;
         default:                return a & b;    // OP_AND.
      endcase
   endfunction

   always_comb begin
      for (int s = 0; s < dual_issue_pkg::ISSUE_W; s++) begin
         opa[s]    = forward(iss.rs1[s], rdata[(2*s)*DW +: DW]);
         opb[s]    = forward(iss.rs2[s], rdata[(2*s+1)*DW +: DW]);
         result[s] = alu(iss.op[s], opa[s], opb[s]);
         waddr[s*AW +: AW] = iss.rd[s];            // Write port s belongs to slot s.
         wdata[s*DW +: DW] = result[s];
      end
   end

   assign we = {dual_issue_pkg::ISSUE_W{iss.valid}}; // Both slots always write back.

   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         retire_valid <= 1'b0;
      end else begin
         retire_valid <= iss.valid;                // One cycle after decode hands over.
      end
   end

   // Retired results also feed the forwarding path of the next pair.
   always_ff @(posedge CLK) begin
      if (iss.valid) begin
         retire_rd0   <= iss.rd[0];
         retire_rd1   <= iss.rd[1];
         retire_data0 <= result[0];
         retire_data1 <= result[1];
      end
   end

endmodule

//--- verilog/issue_if.sv
/*
 Issue bus between decode and execute.
 Carries one decoded instruction pair with a single valid bit.
*/

`timescale 1ns/100ps

interface issue_if;

   logic                       valid;                       // A pair is present this cycle.
   dual_issue_pkg::alu_op_e   op  [dual_issue_pkg::ISSUE_W]; // Operation per slot.
   dual_issue_pkg::reg_addr_t rd  [dual_issue_pkg::ISSUE_W]; // Destination per slot.
   dual_issue_pkg::reg_addr_t rs1 [dual_issue_pkg::ISSUE_W]; // First source per slot.
   dual_issue_pkg::reg_addr_t rs2 [dual_issue_pkg::ISSUE_W]; // Second source per slot.

   // Decode owns the bus.
   modport producer (
      output valid,
      output op,
      output rd,
      output rs1,
      output rs2
   );

   // Execute only samples it.
   modport consumer (
      input valid,
      input op,
      input rd,
      input rs1,
      input rs2
   );

endinterface

//--- verilog/register_file.sv
/*
 Multi-port register file.
 Parameterized read and write port counts, registered read data and a
 reset to a per-register vector. The highest write port wins a clash.
*/

`timescale 1ns/100ps

module register_file #(
   parameter int DW        = 32,
   parameter int AW        = 4,
   parameter int NUM_READ  = 4,
   parameter int NUM_WRITE = 2,
   parameter logic [DW*(1<<AW)-1:0] RST_VECTOR = '0
) (
   input  logic                    CLK,
   input  logic                    RST,
   input  logic [NUM_READ-1:0]     re,
   input  logic [NUM_READ*AW-1:0]  raddr,
   output logic [NUM_READ*DW-1:0]  rdata,
   input  logic [NUM_WRITE-1:0]    we,
   input  logic [NUM_WRITE*AW-1:0] waddr,
   input  logic [NUM_WRITE*DW-1:0] wdata
);

   localparam int DEPTH = 1 << AW;                 // Number of registers.

   logic [DW-1:0] regs   [DEPTH];                  // Architectural state.
   logic [DW-1:0] rd_reg [NUM_READ];               // One output register per read port.

   // Later ports overwrite earlier ones in the loop, so port NUM_WRITE-1 has top priority.
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         for (int i = 0; i < DEPTH; i++) begin
            regs[i] <= RST_VECTOR[i*DW +: DW];     // Each register gets its own reset value.
         end
      end else begin
         for (int j = 0; j < NUM_WRITE; j++) begin
            if (we[j]) begin
               regs[waddr[j*AW +: AW]] <= wdata[j*DW +: DW];
            end
         end
      end
   end

   // Reads see the array as it was before this edge's writes.
   for (genvar p = 0; p < NUM_READ; p++) begin : g_read
      always_ff @(posedge CLK) begin
         if (re[p]) begin
            rd_reg[p] <= regs[raddr[p*AW +: AW]];  // Held while the enable is low.
         end
      end

      assign rdata[p*DW +: DW] = rd_reg[p];
   end

endmodule
